// File: Makefile
# Verilator build and run for the bundle decoder testbench
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= decodeWex3Tb
FLAGS ?= --binary --assert --timing -j 0
LOG ?= sim.log
OBJDIR ?= obj_dir

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f verilog.f
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: design/bundleRoute.sv
// slot router for the bundle decoder
// maps lanes to slots A, B and C, stamps predicates, registers outputs

`timescale 1ns/1ps

module bundleRoute
(
	input  logic clock,
	input  logic arstN,
	input  decodePkg::bundleModeT bundleMode,
	input  logic lanePred [decodePkg::laneCount],
	input  logic lanePredFalse [decodePkg::laneCount],
	input  decodePkg::regIdT laneRegN [decodePkg::laneCount],
	input  decodePkg::regIdT laneRegM [decodePkg::laneCount],
	input  decodePkg::regIdT laneRegO [decodePkg::laneCount],
	input  decodePkg::immT laneImm [decodePkg::laneCount],
	input  decodePkg::uCmdT laneUCmd [decodePkg::laneCount],
	input  decodePkg::uIxtT laneUIxt [decodePkg::laneCount],
	output decodePkg::regIdT idRegS,
	output decodePkg::regIdT idRegT,
	output decodePkg::regIdT idRegM,
	output decodePkg::immT idImmA,
	output decodePkg::uCmdT idUCmdA,
	output decodePkg::uIxtT idUIxtA,
	output decodePkg::regIdT idRegU,
	output decodePkg::regIdT idRegV,
	output decodePkg::regIdT idRegN,
	output decodePkg::immT idImmB,
	output decodePkg::uCmdT idUCmdB,
	output decodePkg::uIxtT idUIxtB,
	output decodePkg::regIdT idRegX,
	output decodePkg::regIdT idRegY,
	output decodePkg::regIdT idRegO,
	output decodePkg::immT idImmC,
	output decodePkg::uCmdT idUCmdC,
	output decodePkg::uIxtT idUIxtC
);

	import decodePkg::*;

	// slot index 0 is A, 1 is B, 2 is C
	regIdT slotRegMNext [laneCount];
	regIdT slotRegONext [laneCount];
	regIdT slotRegNNext [laneCount];
	immT slotImmNext [laneCount];
	uCmdT slotCmdNext [laneCount];
	uIxtT slotIxtNext [laneCount];

	regIdT slotRegM [laneCount];
	regIdT slotRegO [laneCount];
	regIdT slotRegN [laneCount];
	immT slotImm [laneCount];
	uCmdT slotCmd [laneCount];
	uIxtT slotIxt [laneCount];

	uCmdT laneCmdStamped [laneCount];

	// a lane keeps its own predicate in whichever slot it lands
	always_comb
	begin
		condT cond;
		cond = condAlways;
		for (int i = 0; i < laneCount; i++)
		begin
			cond = lanePredFalse[i] ? condFalse : condTrue;
			laneCmdStamped[i] = laneUCmd[i];
			if (lanePred[i])
			begin
				laneCmdStamped[i][cmdWidth-1 -: condWidth] = cond;
			end
		end
	end

	always_comb
	begin
		for (int s = 0; s < laneCount; s++)
		begin
			slotRegMNext[s] = regZero;
			slotRegONext[s] = regZero;
			slotRegNNext[s] = regZero;
			slotImmNext[s] = '0;
			slotCmdNext[s] = '0;
			slotIxtNext[s] = '0;
		end

		case (bundleMode)
			modeWex3:
			begin
				// reversed order, last lane goes to slot A
				for (int s = 0; s < laneCount; s++)
				begin
					slotRegMNext[s] = laneRegM[laneCount-1-s];
					slotRegONext[s] = laneRegO[laneCount-1-s];
					slotRegNNext[s] = laneRegN[laneCount-1-s];
					slotImmNext[s] = laneImm[laneCount-1-s];
					slotCmdNext[s] = laneCmdStamped[laneCount-1-s];
					slotIxtNext[s] = laneUIxt[laneCount-1-s];
				end
			end
			modeWex2:
			begin
				for (int s = 0; s < 2; s++)
				begin
					slotRegMNext[s] = laneRegM[1-s];
					slotRegONext[s] = laneRegO[1-s];
					slotRegNNext[s] = laneRegN[1-s];
					slotImmNext[s] = laneImm[1-s];
					slotCmdNext[s] = laneCmdStamped[1-s];
					slotIxtNext[s] = laneUIxt[1-s];
				end
				// idle slot C still reads both destinations
				slotRegMNext[2] = laneRegN[0];
				slotRegONext[2] = laneRegN[1];
			end
			modeScalar:
			begin
				slotRegMNext[0] = laneRegM[0];
				slotRegONext[0] = laneRegO[0];
				slotRegNNext[0] = laneRegN[0];
				slotImmNext[0] = laneImm[0];
				slotCmdNext[0] = laneCmdStamped[0];
				slotIxtNext[0] = laneUIxt[0];
				slotRegONext[1] = laneRegN[0];
				slotRegONext[2] = laneRegN[0];
			end
			default:
			begin
				// not a wide op, all slots stay inactive
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int s = 0; s < laneCount; s++)
			begin
				slotRegM[s] <= regZero;
				slotRegO[s] <= regZero;
				slotRegN[s] <= regZero;
				slotImm[s] <= '0;
				slotCmd[s] <= '0;
				slotIxt[s] <= '0;
			end
		end
		else
		begin
			slotRegM <= slotRegMNext;
			slotRegO <= slotRegONext;
			slotRegN <= slotRegNNext;
			slotImm <= slotImmNext;
			slotCmd <= slotCmdNext;
			slotIxt <= slotIxtNext;
		end
	end

	// slot A
	assign idRegS = slotRegM[0];
	assign idRegT = slotRegO[0];
	assign idRegM = slotRegN[0];
	assign idImmA = slotImm[0];
	assign idUCmdA = slotCmd[0];
	assign idUIxtA = slotIxt[0];

	// slot B
	assign idRegU = slotRegM[1];
	assign idRegV = slotRegO[1];
	assign idRegN = slotRegN[1];
	assign idImmB = slotImm[1];
	assign idUCmdB = slotCmd[1];
	assign idUIxtB = slotIxt[1];

	// slot C
	assign idRegX = slotRegM[2];
	assign idRegY = slotRegO[2];
	assign idRegO = slotRegN[2];
	assign idImmC = slotImm[2];
	assign idUCmdC = slotCmd[2];
	assign idUIxtC = slotIxt[2];

endmodule

// File: design/decodePkg.sv
// shared widths, field types and register constants
// condition codes and the bundle mode encoding for the wide decoder

package decodePkg;

	// bundle geometry
	localparam int laneCount = 3;
	localparam int laneWidth = 32;

	// decoded field widths
	localparam int regIdWidth = 6;
	localparam int immWidth = 33;
	localparam int immFieldWidth = 10;
	localparam int cmdWidth = 8;
	localparam int ixtWidth = 8;
	localparam int condWidth = 2;
	localparam int prefixWidth = 4;

	// one lane and the full fetch word
	typedef logic [laneWidth-1:0] laneWordT;
	typedef logic [laneCount*laneWidth-1:0] bundleWordT;

	typedef logic [regIdWidth-1:0] regIdT;
	typedef logic [immWidth-1:0] immT;

	// command, top two bits hold the condition
	typedef logic [cmdWidth-1:0] uCmdT;
	typedef logic [ixtWidth-1:0] uIxtT;
	typedef logic [condWidth-1:0] condT;
	typedef logic [prefixWidth-1:0] prefixT;

	// zero register, reads as zero and discards writes
	localparam regIdT regZero = 6'h00;

	// predicate conditions stamped into the command
	localparam condT condAlways = 2'd0;
	localparam condT condTrue = 2'd2;
	localparam condT condFalse = 2'd3;

	// lane prefix in bits 15:12
	localparam prefixT prefixPred = 4'hE;
	localparam prefixT prefixUncond = 4'hF;

	// how many lanes of the fetch word issue together
	typedef enum logic [1:0]
	{
		modeNone = 2'd0,
		modeScalar = 2'd1,
		modeWex2 = 2'd2,
		modeWex3 = 2'd3
	} bundleModeT;

endpackage

// File: design/decodeWex3.sv
// three wide bundle decoder top level
// classifier, one field decoder per lane and the registered router

`timescale 1ns/1ps

module decodeWex3
(
	input  logic clock,
	input  logic arstN,
	input  decodePkg::bundleWordT istrWord,
	input  logic srWxe,
	output decodePkg::regIdT idRegS,
	output decodePkg::regIdT idRegT,
	output decodePkg::regIdT idRegM,
	output decodePkg::immT idImmA,
	output decodePkg::uCmdT idUCmdA,
	output decodePkg::uIxtT idUIxtA,
	output decodePkg::regIdT idRegU,
	output decodePkg::regIdT idRegV,
	output decodePkg::regIdT idRegN,
	output decodePkg::immT idImmB,
	output decodePkg::uCmdT idUCmdB,
	output decodePkg::uIxtT idUIxtB,
	output decodePkg::regIdT idRegX,
	output decodePkg::regIdT idRegY,
	output decodePkg::regIdT idRegO,
	output decodePkg::immT idImmC,
	output decodePkg::uCmdT idUCmdC,
	output decodePkg::uIxtT idUIxtC
);

	import decodePkg::*;

	laneWordT laneWord [laneCount];
	logic lanePred [laneCount];
	logic lanePredFalse [laneCount];
	bundleModeT bundleMode;

	regIdT laneRegN [laneCount];
	regIdT laneRegM [laneCount];
	regIdT laneRegO [laneCount];
	immT laneImm [laneCount];
	uCmdT laneUCmd [laneCount];
	uIxtT laneUIxt [laneCount];

	laneClassify classify_i
	(
		.istrWord(istrWord),
		.srWxe(srWxe),
		.laneWord(laneWord),
		.lanePred(lanePred),
		.lanePredFalse(lanePredFalse),
		.bundleMode(bundleMode)
	);

	// every lane decodes in parallel, routing picks what issues
	for (genvar i = 0; i < laneCount; i++)
	begin : gLane
		laneDecode decode_i
		(
			.laneWord(laneWord[i]),
			.regN(laneRegN[i]),
			.regM(laneRegM[i]),
			.regO(laneRegO[i]),
			.imm(laneImm[i]),
			.uCmd(laneUCmd[i]),
			.uIxt(laneUIxt[i])
		);
	end

	bundleRoute route_i
	(
		.clock(clock),
		.arstN(arstN),
		.bundleMode(bundleMode),
		.lanePred(lanePred),
		.lanePredFalse(lanePredFalse),
		.laneRegN(laneRegN),
		.laneRegM(laneRegM),
		.laneRegO(laneRegO),
		.laneImm(laneImm),
		.laneUCmd(laneUCmd),
		.laneUIxt(laneUIxt),
		.idRegS(idRegS),
		.idRegT(idRegT),
		.idRegM(idRegM),
		.idImmA(idImmA),
		.idUCmdA(idUCmdA),
		.idUIxtA(idUIxtA),
		.idRegU(idRegU),
		.idRegV(idRegV),
		.idRegN(idRegN),
		.idImmB(idImmB),
		.idUCmdB(idUCmdB),
		.idUIxtB(idUIxtB),
		.idRegX(idRegX),
		.idRegY(idRegY),
		.idRegO(idRegO),
		.idImmC(idImmC),
		.idUCmdC(idUCmdC),
		.idUIxtC(idUIxtC)
	);

endmodule

// File: design/laneClassify.sv
// lane classifier for the three lane bundle decoder
// splits the fetch word, checks the prefixes and picks the bundle mode

`timescale 1ns/1ps

module laneClassify
(
	input  decodePkg::bundleWordT istrWord,
	input  logic srWxe,
	output decodePkg::laneWordT laneWord [decodePkg::laneCount],
	output logic lanePred [decodePkg::laneCount],
	output logic lanePredFalse [decodePkg::laneCount],
	output decodePkg::bundleModeT bundleMode
);

	import decodePkg::*;

	logic laneUncond [laneCount];
	logic laneWex [laneCount];
	laneWordT laneSlice [laneCount];

	// lane i sits in bits 32i+31 down to 32i
	always_comb
	begin
		for (int i = 0; i < laneCount; i++)
		begin
			laneSlice[i] = istrWord[i*laneWidth +: laneWidth];
		end
	end

	always_comb
	begin
		prefixT prefix;
		prefix = '0;
		for (int i = 0; i < laneCount; i++)
		begin
			prefix = laneSlice[i][15:12];
			laneWord[i] = laneSlice[i];
			lanePred[i] = (prefix == prefixPred);
			laneUncond[i] = (prefix == prefixUncond);

			// bit 10 selects the false sense of a predicated op
			lanePredFalse[i] = lanePred[i] && laneSlice[i][10];

			// wide flag, F uses bit 10 and E needs bits 11 and 9
			laneWex[i] = srWxe &&
				((laneUncond[i] && laneSlice[i][10]) ||
				(lanePred[i] && laneSlice[i][11] && laneSlice[i][9]));
		end
	end

	// only lanes 0 and 1 decide the width of the bundle
	always_comb
	begin
		if (!(lanePred[0] || laneUncond[0]))
		begin
			bundleMode = modeNone;
		end
		else if (laneWex[0] && laneWex[1])
		begin
			bundleMode = modeWex3;
		end
		else if (laneWex[0])
		begin
			bundleMode = modeWex2;
		end
		else
		begin
			bundleMode = modeScalar;
		end
	end

endmodule

// File: design/laneDecode.sv
// field decoder for one 32 bit lane
// pulls out registers, immediate, command and extension

`timescale 1ns/1ps

module laneDecode
(
	input  decodePkg::laneWordT laneWord,
	output decodePkg::regIdT regN,
	output decodePkg::regIdT regM,
	output decodePkg::regIdT regO,
	output decodePkg::immT imm,
	output decodePkg::uCmdT uCmd,
	output decodePkg::uIxtT uIxt
);

	import decodePkg::*;

	logic [immFieldWidth-1:0] immField;
	logic [cmdWidth-condWidth-1:0] opField;

	// high register bits live in the upper half of the lane
	assign regN = {laneWord[25:24], laneWord[7:4]};
	assign regM = {laneWord[23:22], laneWord[3:0]};
	assign regO = {laneWord[21:20], laneWord[19:16]};

	// 10 bit immediate, sign extended to full width
	assign immField = laneWord[25:16];
	assign imm = {{(immWidth-immFieldWidth){immField[immFieldWidth-1]}}, immField};

	// opcode bits, condition filled in later by the router
	assign opField = laneWord[31:26];
	assign uCmd = {condAlways, opField};

	assign uIxt = laneWord[23:16];

endmodule

// File: verif/decodeWex3Tb.sv
// testbench for the three lane bundle decoder
// stimulus table and random bundles, reference routing model, output checks

`timescale 1ns/1ps

module decodeWex3Tb;

	import decodePkg::*;

	localparam int resetCycles = 16;
	localparam int tableLen = 12;
	localparam int randomCount = 200;
	localparam int cycleLimit = resetCycles + tableLen + randomCount + 20;
	localparam int clockHalf = 50;
	localparam int driveDelay = 5;

	logic clock;
	logic arstN;
	bundleWordT istrWord;
	logic srWxe;
	regIdT idRegS, idRegT, idRegM;
	regIdT idRegU, idRegV, idRegN;
	regIdT idRegX, idRegY, idRegO;
	immT idImmA, idImmB, idImmC;
	uCmdT idUCmdA, idUCmdB, idUCmdC;
	uIxtT idUIxtA, idUIxtB, idUIxtC;

	// expected slot contents with slot A at index 0
	regIdT expRegM [laneCount];
	regIdT expRegO [laneCount];
	regIdT expRegN [laneCount];
	immT expImm [laneCount];
	uCmdT expCmd [laneCount];
	uIxtT expIxt [laneCount];

	bundleWordT tableWord [tableLen];
	logic tableWxe [tableLen];
	bundleModeT tableMode [tableLen];

	int errorCount;
	int checkCount;
	int cycleCount;
	integer seed;

	decodeWex3 dut_i (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#clockHalf clock = ~clock;
	end

	task automatic setEntry(input int idx, input bundleWordT word, input logic wxe,
		input bundleModeT mode);
		tableWord[idx] = word;
		tableWxe[idx] = wxe;
		tableMode[idx] = mode;
	endtask

	// words are {lane 2, lane 1, lane 0}
	task automatic loadTable();
		setEntry(0, {32'h0000_0000, 32'hDEAD_BEEF, 32'h1234_F0A5}, 1'b1, modeScalar);
		setEntry(1, {32'h0000_0000, 32'h0000_0000, 32'h5678_E0C3}, 1'b1, modeScalar);
		setEntry(2, {32'h1357_9BDF, 32'h2468_ACE0, 32'h9ABC_E43C}, 1'b1, modeScalar);
		setEntry(3, {32'h5555_AAAA, 32'h3C3C_E077, 32'hA5A5_F412}, 1'b1, modeWex2);
		setEntry(4, {32'h5555_AAAA, 32'h3C3C_E077, 32'hA5A5_F412}, 1'b0, modeScalar);
		setEntry(5, {32'hC0DE_EE10, 32'h8765_F421, 32'h4321_EA9B}, 1'b1, modeWex3);
		setEntry(6, {32'h0F0F_F0F0, 32'h0000_F000, 32'hFFFF_EEFF}, 1'b1, modeWex2);
		setEntry(7, {32'h3333_EE33, 32'h2222_F422, 32'h1111_1111}, 1'b1, modeNone);
		setEntry(8, {32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_0FFF}, 1'b1, modeNone);
		setEntry(9, {32'h7777_F777, 32'h7777_E777, 32'h7777_D777}, 1'b0, modeNone);
		setEntry(10, {32'hC0DE_EE10, 32'h8765_F421, 32'h4321_EA9B}, 1'b0, modeScalar);
		setEntry(11, {32'h0000_0000, 32'h0000_0000, 32'hFE00_F0F0}, 1'b1, modeScalar);
	endtask

	function automatic laneWordT laneOf(input bundleWordT word, input int idx);
		return word[idx*32 +: 32];
	endfunction

	// F needs bit 10 and E needs bits 11 and 9 while srWxe is high
	function automatic logic isWide(input laneWordT lane, input logic wxe);
		logic wide;
		wide = 1'b0;
		if (lane[15:12] == prefixUncond)
			wide = lane[10];
		else if (lane[15:12] == prefixPred)
			wide = lane[11] & lane[9];
		return wide & wxe;
	endfunction

	function automatic bundleModeT classifyBundle(input bundleWordT word, input logic wxe);
		laneWordT lane0;
		laneWordT lane1;
		bundleModeT mode;
		lane0 = laneOf(word, 0);
		lane1 = laneOf(word, 1);
		if (lane0[15:12] != prefixPred && lane0[15:12] != prefixUncond)
			mode = modeNone;
		else if (isWide(lane0, wxe) && isWide(lane1, wxe))
			mode = modeWex3;
		else if (isWide(lane0, wxe))
			mode = modeWex2;
		else
			mode = modeScalar;
		return mode;
	endfunction

	function automatic condT laneCond(input laneWordT lane);
		if (lane[15:12] != prefixPred)
			return condAlways;
		return lane[10] ? condFalse : condTrue;
	endfunction

	function automatic regIdT laneDest(input laneWordT lane);
		return {lane[25:24], lane[7:4]};
	endfunction

	task automatic clearExpected();
		for (int s = 0; s < laneCount; s++)
		begin
			expRegM[s] = regZero;
			expRegO[s] = regZero;
			expRegN[s] = regZero;
			expImm[s] = '0;
			expCmd[s] = '0;
			expIxt[s] = '0;
		end
	endtask

	// whole lane in one slot with its own predicate stamp
	task automatic fillSlot(input int s, input laneWordT lane);
		expRegM[s] = {lane[23:22], lane[3:0]};
		expRegO[s] = {lane[21:20], lane[19:16]};
		expRegN[s] = laneDest(lane);
		expImm[s] = {{23{lane[25]}}, lane[25:16]};
		expCmd[s] = {laneCond(lane), lane[31:26]};
		expIxt[s] = lane[23:16];
	endtask

	task automatic predictSlots(input bundleWordT word, input bundleModeT mode);
		clearExpected();
		case (mode)
			modeWex3:
			begin
				fillSlot(0, laneOf(word, 2));
				fillSlot(1, laneOf(word, 1));
				fillSlot(2, laneOf(word, 0));
			end
			modeWex2:
			begin
				fillSlot(0, laneOf(word, 1));
				fillSlot(1, laneOf(word, 0));
				expRegM[2] = laneDest(laneOf(word, 0));
				expRegO[2] = laneDest(laneOf(word, 1));
			end
			modeScalar:
			begin
				fillSlot(0, laneOf(word, 0));
				expRegO[1] = laneDest(laneOf(word, 0));
				expRegO[2] = laneDest(laneOf(word, 0));
			end
			default:
			begin
				// nothing issues
			end
		endcase
	endtask

	task automatic randomBundle(output bundleWordT word, output logic wxe);
		laneWordT lane [laneCount];
		logic [31:0] pick;
		for (int i = 0; i < laneCount; i++)
		begin
			lane[i] = $random(seed);
			pick = $random(seed);
			// most lanes get an E or F prefix so wide modes show up
			if (pick[1:0] != 2'b00)
				lane[i][15:13] = 3'b111;
		end
		pick = $random(seed);
		wxe = (pick[1:0] != 2'b00);
		word = {lane[2], lane[1], lane[0]};
	endtask

	task automatic checkField(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checkCount++;
		assert (got == exp)
		else
		begin
			errorCount++;
			$display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic checkOutputs();
		checkField("idRegS", 64'(idRegS), 64'(expRegM[0]));
		checkField("idRegT", 64'(idRegT), 64'(expRegO[0]));
		checkField("idRegM", 64'(idRegM), 64'(expRegN[0]));
		checkField("idImmA", 64'(idImmA), 64'(expImm[0]));
		checkField("idUCmdA", 64'(idUCmdA), 64'(expCmd[0]));
		checkField("idUIxtA", 64'(idUIxtA), 64'(expIxt[0]));
		checkField("idRegU", 64'(idRegU), 64'(expRegM[1]));
		checkField("idRegV", 64'(idRegV), 64'(expRegO[1]));
		checkField("idRegN", 64'(idRegN), 64'(expRegN[1]));
		checkField("idImmB", 64'(idImmB), 64'(expImm[1]));
		checkField("idUCmdB", 64'(idUCmdB), 64'(expCmd[1]));
		checkField("idUIxtB", 64'(idUIxtB), 64'(expIxt[1]));
		checkField("idRegX", 64'(idRegX), 64'(expRegM[2]));
		checkField("idRegY", 64'(idRegY), 64'(expRegO[2]));
		checkField("idRegO", 64'(idRegO), 64'(expRegN[2]));
		checkField("idImmC", 64'(idImmC), 64'(expImm[2]));
		checkField("idUCmdC", 64'(idUCmdC), 64'(expCmd[2]));
		checkField("idUIxtC", 64'(idUIxtC), 64'(expIxt[2]));
	endtask

	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: the run did not complete within %0d cycles", cycleLimit);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		bundleWordT word;
		logic wxe;
		bundleModeT mode;
		int assertFails;
		seed = 77;
		errorCount = 0;
		checkCount = 0;
		arstN = 1'b0;
		istrWord = '0;
		srWxe = 1'b0;
		mode = modeNone;
		loadTable();
		clearExpected();
		repeat (resetCycles) @(posedge clock);
		#driveDelay;
		checkOutputs();
		arstN = 1'b1;

		// each check sees the bundle driven one edge earlier
		for (int k = 0; k < tableLen + randomCount; k++)
		begin
			@(posedge clock);
			#driveDelay;
			checkOutputs();
			// classifier result for the bundle still on the inputs
			if (k > 0)
				checkField("bundleMode", 64'(dut_i.bundleMode), 64'(mode));
			if (k < tableLen)
			begin
				word = tableWord[k];
				wxe = tableWxe[k];
				mode = tableMode[k];
			end
			else
			begin
				randomBundle(word, wxe);
				mode = classifyBundle(word, wxe);
			end
			istrWord = word;
			srWxe = wxe;
			predictSlots(word, mode);
		end
		@(posedge clock);
		#driveDelay;
		checkOutputs();
		checkField("bundleMode", 64'(dut_i.bundleMode), 64'(mode));

		assertFails = dut_i.assertions_i.assertFailCount;
		$display("checks: %0d, value errors: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: verif/decodeWex3_assertions.sv
// concurrent checks on the bundle decoder outputs
// reset state, slot C with wide issue off, scalar destination forwarding

`timescale 1ns/1ps

module decodeWex3_assertions
(
	input  logic clock,
	input  logic arstN,
	input  logic srWxe,
	input  decodePkg::uCmdT idUCmdA,
	input  decodePkg::uCmdT idUCmdB,
	input  decodePkg::uCmdT idUCmdC,
	input  decodePkg::regIdT idRegV,
	input  decodePkg::regIdT idRegM
);

	// failures seen so far, read by the testbench at the end
	int assertFailCount = 0;

	// all slots inactive while reset is held
	resetInactive: assert property (@(posedge clock)
		!arstN |-> (idUCmdA == '0 && idUCmdB == '0 && idUCmdC == '0))
	else
	begin
		assertFailCount++;
		$error("command output is not zero while reset is asserted");
	end

	// with wide issue off only scalar or none can issue, so slot C stays idle
	slotCIdle: assert property (@(posedge clock) disable iff (!arstN)
		!srWxe |=> idUCmdC == '0)
	else
	begin
		assertFailCount++;
		$error("slot C issued a command while wide issue was disabled");
	end

	// scalar issue, slot B Ro carries lane 0 Rn which is also slot A Rn
	scalarForward: assert property (@(posedge clock) disable iff (!arstN)
		($past(!srWxe) && idUCmdB == '0 && idUCmdA != '0) |-> idRegV == idRegM)
	else
	begin
		assertFailCount++;
		$error("scalar bundle did not forward its destination to slot B");
	end

endmodule

bind decodeWex3 decodeWex3_assertions assertions_i
(
	.clock(clock),
	.arstN(arstN),
	.srWxe(srWxe),
	.idUCmdA(idUCmdA),
	.idUCmdB(idUCmdB),
	.idUCmdC(idUCmdC),
	.idRegV(idRegV),
	.idRegM(idRegM)
);

// File: verilog.f
design/decodePkg.sv
design/laneClassify.sv
design/laneDecode.sv
design/bundleRoute.sv
design/decodeWex3.sv
verif/decodeWex3_assertions.sv
verif/decodeWex3Tb.sv
